// File: rtl/tart_bus_pkg.sv
package tart_bus_pkg;

   // ------------------------------
   // Bus widths
   // ------------------------------
   localparam int BUS_BITS  = 8;  // APB data width
   localparam int ADDR_BITS = 8;  // APB byte address width
   localparam int LOC_BITS  = 3;  // Register offset inside a unit

   // APB request from the host, setup then access phase
   typedef struct packed {
      logic [ADDR_BITS-1:0] paddr;
      logic                 pwrite;
      logic [BUS_BITS-1:0]  pwdata;
      logic                 psel;
      logic                 penable;
   } apb_req_t;

   // Target of the current access
   typedef enum logic [1:0] {
      UNIT_ACQ  = 2'd0,
      UNIT_CTRL = 2'd1,
      UNIT_NONE = 2'd2
   } unit_e;

   // Decoded request as seen by the units
   typedef struct packed {
      unit_e                unit;
      logic [LOC_BITS-1:0]  addr;    // Offset from the unit base
      logic                 write;
      logic [BUS_BITS-1:0]  wdata;
      logic                 strobe;  // First access cycle only
   } bus_sel_t;

   // ------------------------------
   // Register map
   // ------------------------------
   localparam logic [ADDR_BITS-1:0] ACQ_BASE  = 8'h00;
   localparam int                   ACQ_WIN   = 3;  // 8-byte window
   localparam logic [ADDR_BITS-1:0] CTRL_BASE = 8'h0C;
   localparam int                   CTRL_WIN  = 2;  // 4-byte window

   // Acquisition unit offsets
   localparam logic [LOC_BITS-1:0] AQ_CTRL  = 3'd0;  // Enable, debug, delay
   localparam logic [LOC_BITS-1:0] AQ_RAW   = 3'd1;  // Pops sample FIFO
   localparam logic [LOC_BITS-1:0] AQ_VIS   = 3'd2;  // Pops visibility FIFO
   localparam logic [LOC_BITS-1:0] AQ_LEVEL = 3'd3;  // {vis count, raw count}
   localparam logic [LOC_BITS-1:0] AQ_BLOCK = 3'd4;  // Visibility word counter

   // Reset handler offsets
   localparam logic [LOC_BITS-1:0] CT_RESET    = 3'd0;
   localparam logic [LOC_BITS-1:0] CT_STATUS   = 3'd1;
   localparam logic [LOC_BITS-1:0] CT_CHECKSUM = 3'd2;

endpackage

// File: rtl/tart_data_pkg.sv
package tart_data_pkg;

   // ------------------------------
   // Antenna side
   // ------------------------------
   localparam int ANT_BITS = 6;  // Default number of antennae
   localparam int TAG_BITS = 2;  // Sample sequence tag
   localparam int VIS_BITS = 8;  // Correlator word width

   // One raw sample across all antennae
   typedef struct packed {
      logic [TAG_BITS-1:0] tag;  // Upper bits
      logic [ANT_BITS-1:0] ant;  // One bit per antenna
   } sample_t;

   // Correlator output word
   typedef struct packed {
      logic [VIS_BITS-1:0] word;
   } vis_t;

   // ------------------------------
   // Acquisition settings
   // ------------------------------
   // Layout matches AQ_CTRL bits 4..0
   typedef struct packed {
      logic       enable;  // Bit 4, gates capture
      logic       debug;   // Bit 3, debug mode
      logic [2:0] delay;   // Bits 2..0, sample delay
   } aq_cfg_t;

   localparam int CFG_BITS = $bits(aq_cfg_t);

endpackage

// File: rtl/tart_stream_fifo.sv
module tart_stream_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  DEPTH  = 8
) (
   input  logic                       b_clk,
   input  logic                       arst_n_i,
   input  logic                       clear_i,   // Synchronous flush
   input  logic                       push_i,
   input  item_t                      data_i,
   input  logic                       pop_i,
   output item_t                      data_o,    // Head of queue
   output logic                       full_o,
   output logic                       empty_o,
   output logic [$clog2(DEPTH+1)-1:0] count_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   item_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] cnt_q;
   logic          do_push;
   logic          do_pop;

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else if (clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (do_push)
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (do_push != do_pop)
            cnt_q <= do_push ? cnt_q + 1'b1 : cnt_q - 1'b1;
      end
   end

   // Storage, readable one cycle after the write
   always_ff @(posedge b_clk) begin
      if (do_push && !clear_i) mem[wr_ptr_q] <= data_i;
   end

   assign data_o  = mem[rd_ptr_q];
   assign full_o  = (cnt_q == CW'(DEPTH));
   assign empty_o = (cnt_q == '0);
   assign count_o = cnt_q;

   // Producer must hold off while full
   a_no_full_push : assert property (@(posedge b_clk) disable iff (!arst_n_i)
      (push_i && !clear_i) |-> !full_o);

endmodule

// File: rtl/tart_apb_decode.sv
module tart_apb_decode (
   input  logic                   b_clk,
   input  logic                   arst_n_i,
   input  tart_bus_pkg::apb_req_t req_i,
   output tart_bus_pkg::bus_sel_t sel_o,
   output logic                   unmapped_o
);

   localparam int AW = tart_bus_pkg::ADDR_BITS;
   localparam int LW = tart_bus_pkg::LOC_BITS;

   logic                access;   // psel and penable both high
   logic                busy_q;   // Past the first access cycle
   logic [AW-1:0]       base;     // Base of the hit window
   tart_bus_pkg::unit_e unit_d;   // Decoded from paddr
   tart_bus_pkg::unit_e unit_q;   // Held for the rest of the access

   assign access = req_i.psel & req_i.penable;

   // ------------------------------
   // Window compare
   // ------------------------------
   always_comb begin
      unit_d = tart_bus_pkg::UNIT_NONE;
      base   = '0;
      if ((req_i.paddr >> tart_bus_pkg::ACQ_WIN) ==
          (tart_bus_pkg::ACQ_BASE >> tart_bus_pkg::ACQ_WIN)) begin
         unit_d = tart_bus_pkg::UNIT_ACQ;
         base   = tart_bus_pkg::ACQ_BASE;
      end else if ((req_i.paddr >> tart_bus_pkg::CTRL_WIN) ==
                   (tart_bus_pkg::CTRL_BASE >> tart_bus_pkg::CTRL_WIN)) begin
         unit_d = tart_bus_pkg::UNIT_CTRL;
         base   = tart_bus_pkg::CTRL_BASE;
      end
   end

   // First-cycle tracking until the next setup phase
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q <= 1'b0;
         unit_q <= tart_bus_pkg::UNIT_NONE;
      end else begin
         busy_q <= access;
         if (access && !busy_q) unit_q <= unit_d;  // Latch at strobe
      end
   end

   always_comb begin
      sel_o.unit   = busy_q ? unit_q : unit_d;
      sel_o.addr   = LW'(req_i.paddr - base);  // Local register offset
      sel_o.write  = req_i.pwrite;
      sel_o.wdata  = req_i.pwdata;
      sel_o.strobe = access & ~busy_q;          // One pulse per access
   end

   assign unmapped_o = (unit_d == tart_bus_pkg::UNIT_NONE);

   // Back-to-back accesses still need a setup cycle between strobes
   a_strobe_single : assert property (@(posedge b_clk) disable iff (!arst_n_i)
      sel_o.strobe |-> $past(req_i.psel && !req_i.penable));

endmodule

// File: rtl/tart_control.sv
module tart_control #(
   parameter int RTIME = 4  // Soft reset length in cycles
) (
   input  logic                                b_clk,
   input  logic                                arst_n_i,
   input  tart_bus_pkg::bus_sel_t              sel_i,
   output logic [tart_bus_pkg::BUS_BITS-1:0]   rdata_o,
   output logic                                soft_rst_o,
   input  logic [tart_bus_pkg::BUS_BITS-1:0]   status_i,    // Flags from acquire
   input  logic [tart_bus_pkg::BUS_BITS-1:0]   checksum_i
);

   localparam int CW = $clog2(RTIME + 1);
   localparam int BW = tart_bus_pkg::BUS_BITS;

   logic          hit;
   logic          start;    // Host reset request
   logic [CW-1:0] cnt_q;    // Remaining soft-reset cycles
   logic          busy;
   logic [BW-1:0] status;   // Status with busy bit merged

   assign hit   = sel_i.strobe && (sel_i.unit == tart_bus_pkg::UNIT_CTRL);
   assign start = hit && sel_i.write && (sel_i.addr == tart_bus_pkg::CT_RESET)
                  && sel_i.wdata[0];
   assign busy  = (cnt_q != '0);

   // ------------------------------
   // Reset stretcher
   // ------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (start && !busy) begin
         cnt_q <= CW'(RTIME);   // Requests during a reset are ignored
      end else if (busy) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   assign soft_rst_o = busy;

   // Bit 2 of the status byte is owned here
   always_comb begin
      status    = status_i;
      status[2] = busy;
   end

   // Register read-back
   always_comb begin
      case (sel_i.addr)
         tart_bus_pkg::CT_RESET:    rdata_o = BW'(busy);
         tart_bus_pkg::CT_STATUS:   rdata_o = status;
         tart_bus_pkg::CT_CHECKSUM: rdata_o = checksum_i;
         default:                   rdata_o = '0;
      endcase
   end

   // Acquire sees exactly RTIME cycles of soft reset per request
   a_rst_len : assert property (@(posedge b_clk) disable iff (!arst_n_i)
      $rose(soft_rst_o) |-> ##RTIME !soft_rst_o);

endmodule

// File: rtl/tart_acquire.sv
module tart_acquire #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                              b_clk,
   input  logic                              arst_n_i,
   input  logic                              soft_rst_i,
   input  tart_bus_pkg::bus_sel_t            sel_i,
   output logic [tart_bus_pkg::BUS_BITS-1:0] rdata_o,
   input  logic                              sample_valid_i,
   input  tart_data_pkg::sample_t            sample_i,
   input  logic                              vis_valid_i,
   input  tart_data_pkg::vis_t               vis_i,
   output tart_data_pkg::aq_cfg_t            aq_cfg_o,
   output logic [tart_bus_pkg::BUS_BITS-1:0] flags_o,     // Status byte sources
   output logic [tart_bus_pkg::BUS_BITS-1:0] checksum_o
);

   localparam int BW = tart_bus_pkg::BUS_BITS;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   tart_data_pkg::aq_cfg_t  cfg_q;
   tart_data_pkg::sample_t  raw_data;
   tart_data_pkg::vis_t     vis_data;
   logic                    hit, wr, rd;
   logic                    rd_raw, rd_vis;
   logic                    raw_push, raw_pop, raw_full, raw_empty;
   logic                    vis_push, vis_pop, vis_full, vis_empty;
   logic [CW-1:0]           raw_cnt, vis_cnt;
   logic                    uflow_q, oflow_q;    // Sticky until reset
   logic [BW-1:0]           sum_q;               // Visibility checksum
   logic [BW-1:0]           blk_q;               // Words accepted

   // ------------------------------
   // Bus access
   // ------------------------------
   assign hit    = sel_i.strobe && (sel_i.unit == tart_bus_pkg::UNIT_ACQ);
   assign wr     = hit && sel_i.write;
   assign rd     = hit && !sel_i.write;
   assign rd_raw = rd && (sel_i.addr == tart_bus_pkg::AQ_RAW);
   assign rd_vis = rd && (sel_i.addr == tart_bus_pkg::AQ_VIS);

   // Streams cannot stall, so a full FIFO drops the word
   assign raw_push = sample_valid_i && cfg_q.enable && !raw_full;
   assign vis_push = vis_valid_i && !vis_full;
   assign raw_pop  = rd_raw && !raw_empty;  // Pop in the strobe cycle
   assign vis_pop  = rd_vis && !vis_empty;

   tart_stream_fifo #(
      .item_t (tart_data_pkg::sample_t),
      .DEPTH  (FIFO_DEPTH)
   ) u_raw_fifo (
      .b_clk    (b_clk),
      .arst_n_i (arst_n_i),
      .clear_i  (soft_rst_i),
      .push_i   (raw_push),
      .data_i   (sample_i),
      .pop_i    (raw_pop),
      .data_o   (raw_data),
      .full_o   (raw_full),
      .empty_o  (raw_empty),
      .count_o  (raw_cnt)
   );

   tart_stream_fifo #(
      .item_t (tart_data_pkg::vis_t),
      .DEPTH  (FIFO_DEPTH)
   ) u_vis_fifo (
      .b_clk    (b_clk),
      .arst_n_i (arst_n_i),
      .clear_i  (soft_rst_i),
      .push_i   (vis_push),
      .data_i   (vis_i),
      .pop_i    (vis_pop),
      .data_o   (vis_data),
      .full_o   (vis_full),
      .empty_o  (vis_empty),
      .count_o  (vis_cnt)
   );

   // ------------------------------
   // Settings, flags, checksum
   // ------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cfg_q   <= '0;
         uflow_q <= 1'b0;
         oflow_q <= 1'b0;
         sum_q   <= '0;
         blk_q   <= '0;
      end else if (soft_rst_i) begin
         cfg_q   <= '0;
         uflow_q <= 1'b0;
         oflow_q <= 1'b0;
         sum_q   <= '0;
         blk_q   <= '0;
      end else begin
         if (wr && sel_i.addr == tart_bus_pkg::AQ_CTRL)
            cfg_q <= sel_i.wdata[tart_data_pkg::CFG_BITS-1:0];
         if ((rd_raw && raw_empty) || (rd_vis && vis_empty))
            uflow_q <= 1'b1;
         if ((sample_valid_i && cfg_q.enable && raw_full) || (vis_valid_i && vis_full))
            oflow_q <= 1'b1;
         if (vis_push) begin
            sum_q <= sum_q + vis_i.word;  // Wraps modulo 256
            blk_q <= blk_q + 1'b1;
         end
      end
   end

   // Empty reads return zero
   always_comb begin
      case (sel_i.addr)
         tart_bus_pkg::AQ_CTRL:  rdata_o = BW'(cfg_q);
         tart_bus_pkg::AQ_RAW:   rdata_o = raw_empty ? '0 : BW'(raw_data);
         tart_bus_pkg::AQ_VIS:   rdata_o = vis_empty ? '0 : BW'(vis_data);
         tart_bus_pkg::AQ_LEVEL: rdata_o = {4'(vis_cnt), 4'(raw_cnt)};
         tart_bus_pkg::AQ_BLOCK: rdata_o = blk_q;
         default:                rdata_o = '0;
      endcase
   end

   // Bit 2 left clear for the reset handler
   assign flags_o    = {uflow_q, oflow_q, !raw_empty, cfg_q.enable,
                        cfg_q.debug, 1'b0, !vis_empty, 1'b0};
   assign aq_cfg_o   = cfg_q;
   assign checksum_o = sum_q;

   // A read pop takes exactly one word out of a FIFO that holds data
   a_raw_pop_one : assert property (@(posedge b_clk) disable iff (!arst_n_i)
      (raw_pop && !raw_push && !soft_rst_i) |=> (raw_cnt == $past(raw_cnt) - 1'b1));
   a_vis_pop_one : assert property (@(posedge b_clk) disable iff (!arst_n_i)
      (vis_pop && !vis_push && !soft_rst_i) |=> (vis_cnt == $past(vis_cnt) - 1'b1));

endmodule

// File: rtl/tart_result_mux.sv
module tart_result_mux (
   input  logic                              b_clk,
   input  logic                              arst_n_i,
   input  tart_bus_pkg::bus_sel_t            sel_i,
   input  logic                              unmapped_i,
   input  logic [tart_bus_pkg::BUS_BITS-1:0] acq_rdata_i,
   input  logic [tart_bus_pkg::BUS_BITS-1:0] ctrl_rdata_i,
   output logic [tart_bus_pkg::BUS_BITS-1:0] prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o
);

   logic [tart_bus_pkg::BUS_BITS-1:0] rdata_d;
   logic [tart_bus_pkg::BUS_BITS-1:0] prdata_q;
   logic                              pready_q;
   logic                              pslverr_q;

   // Unmapped reads give zero
   always_comb begin
      case (sel_i.unit)
         tart_bus_pkg::UNIT_ACQ:  rdata_d = acq_rdata_i;
         tart_bus_pkg::UNIT_CTRL: rdata_d = ctrl_rdata_i;
         default:                 rdata_d = '0;
      endcase
   end

   // ------------------------------
   // Response, one cycle after strobe
   // ------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pready_q  <= 1'b0;
         pslverr_q <= 1'b0;
      end else begin
         pready_q  <= sel_i.strobe;               // Fixed two-cycle access
         pslverr_q <= sel_i.strobe && unmapped_i;
      end
   end

   // Read data held until the next read
   always_ff @(posedge b_clk) begin
      if (sel_i.strobe && !sel_i.write) prdata_q <= rdata_d;
   end

   assign prdata_o  = prdata_q;
   assign pready_o  = pready_q;
   assign pslverr_o = pslverr_q;

endmodule

// File: rtl/tart_top.sv
module tart_top #(
   parameter int FIFO_DEPTH = 8,  // Per read-back FIFO
   parameter int RTIME      = 4   // Soft reset stretch
) (
   input  logic                              b_clk,
   input  logic                              arst_n_i,
   input  tart_bus_pkg::apb_req_t            req_i,
   output logic [tart_bus_pkg::BUS_BITS-1:0] prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o,
   input  logic                              sample_valid_i,
   input  tart_data_pkg::sample_t            sample_i,
   input  logic                              vis_valid_i,
   input  tart_data_pkg::vis_t               vis_i,
   output tart_data_pkg::aq_cfg_t            aq_cfg_o
);

   tart_bus_pkg::bus_sel_t            sel;
   logic                              unmapped;
   logic                              soft_rst;
   logic [tart_bus_pkg::BUS_BITS-1:0] acq_rdata, ctrl_rdata;
   logic [tart_bus_pkg::BUS_BITS-1:0] flags, checksum;

   // ------------------------------
   // Decode, execute, result
   // ------------------------------
   tart_apb_decode u_decode (
      .b_clk(b_clk), .arst_n_i(arst_n_i),
      .req_i(req_i), .sel_o(sel), .unmapped_o(unmapped)
   );

   tart_control #(.RTIME(RTIME)) u_control (
      .b_clk(b_clk), .arst_n_i(arst_n_i),
      .sel_i(sel), .rdata_o(ctrl_rdata),
      .soft_rst_o(soft_rst),              // Clears acquire only
      .status_i(flags), .checksum_i(checksum)
   );

   tart_acquire #(.FIFO_DEPTH(FIFO_DEPTH)) u_acquire (
      .b_clk(b_clk), .arst_n_i(arst_n_i), .soft_rst_i(soft_rst),
      .sel_i(sel), .rdata_o(acq_rdata),
      .sample_valid_i(sample_valid_i), .sample_i(sample_i),
      .vis_valid_i(vis_valid_i), .vis_i(vis_i),
      .aq_cfg_o(aq_cfg_o), .flags_o(flags), .checksum_o(checksum)
   );

   tart_result_mux u_result (
      .b_clk(b_clk), .arst_n_i(arst_n_i),
      .sel_i(sel), .unmapped_i(unmapped),
      .acq_rdata_i(acq_rdata), .ctrl_rdata_i(ctrl_rdata),
      .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o)
   );

endmodule

// File: verification/tart_tb.sv
module tart_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int BW      = tart_bus_pkg::BUS_BITS;
   localparam int TIMEOUT = 20;  // Cycles allowed for pready

   logic                   b_clk;
   logic                   arst_n_i;
   tart_bus_pkg::apb_req_t req;
   logic [BW-1:0]          prdata;
   logic                   pready;
   logic                   pslverr;
   logic                   sample_valid;
   tart_data_pkg::sample_t sample;
   logic                   vis_valid;
   tart_data_pkg::vis_t    vis;
   tart_data_pkg::aq_cfg_t aq_cfg;

   int data_errs;
   int cfg_errs;
   int resp_errs;
   int other_errs;  // Timeouts, file trouble

   tart_top #(
      .FIFO_DEPTH (8),
      .RTIME      (4)
   ) uut (
      .b_clk          (b_clk),
      .arst_n_i       (arst_n_i),
      .req_i          (req),
      .prdata_o       (prdata),
      .pready_o       (pready),
      .pslverr_o      (pslverr),
      .sample_valid_i (sample_valid),
      .sample_i       (sample),
      .vis_valid_i    (vis_valid),
      .vis_i          (vis),
      .aq_cfg_o       (aq_cfg)
   );

   initial begin
      b_clk = 1'b0;
      forever #20 b_clk = ~b_clk;  // 40 ns period
   end

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_data(input logic [BW-1:0] got, input logic [BW-1:0] exp,
                             input string what);
      if (got !== exp) begin
         data_errs++;
         $display("mismatch at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_cfg(input tart_data_pkg::aq_cfg_t got,
                            input tart_data_pkg::aq_cfg_t exp);
      if (got !== exp) begin
         cfg_errs++;
         $display("mismatch at %0t ns: aq_cfg_o is %b, expected %b", $time, got, exp);
      end
   endtask

   task automatic check_resp(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         resp_errs++;
         $display("mismatch at %0t ns: %s pslverr %b, expected %b", $time, what, got, exp);
      end
   endtask

   // ------------------------------
   // Bus and stream drivers
   // ------------------------------
   // Setup phase, then access phase held until pready
   task automatic apb_transfer(input logic [7:0] addr, input logic wr,
                               input logic [BW-1:0] wdata, output logic [BW-1:0] rdata,
                               output logic err, output int lat);
      lat = 0;
      @(posedge b_clk);
      #2;
      req.paddr   = addr;
      req.pwrite  = wr;
      req.pwdata  = wdata;
      req.psel    = 1'b1;
      req.penable = 1'b0;
      @(posedge b_clk);
      #2;
      req.penable = 1'b1;
      do begin
         @(negedge b_clk);  // Mid-cycle, response is settled
         lat++;
      end while (!pready && lat < TIMEOUT);
      if (!pready) begin
         other_errs++;
         $display("No pready within %0d cycles for address %h", TIMEOUT, addr);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge b_clk);  // Transfer completes here
      #2;
      req.psel    = 1'b0;
      req.penable = 1'b0;
   endtask

   // One word per cycle on the chosen stream
   task automatic drive_stream(input logic is_vis, input logic [7:0] data, input int count);
      for (int i = 0; i < count; i++) begin
         @(posedge b_clk);
         #2;
         sample_valid = !is_vis;
         vis_valid    = is_vis;
         sample       = tart_data_pkg::sample_t'(data);
         vis          = tart_data_pkg::vis_t'(data);
      end
      @(posedge b_clk);
      #2;
      sample_valid = 1'b0;
      vis_valid    = 1'b0;
   endtask

   task automatic idle_check(input int cycles, input tart_data_pkg::aq_cfg_t exp);
      repeat (cycles) @(posedge b_clk);
      @(negedge b_clk);
      check_cfg(aq_cfg, exp);
   endtask

   // ------------------------------
   // Case runner
   // ------------------------------
   initial begin
      int              fd;
      int              n;
      int              lat;
      logic [8*96-1:0] line;
      logic [8*8-1:0]  op;    // Opcode text, right aligned
      logic [31:0]     a, b, c;
      logic [BW-1:0]   rd;
      logic            err;

      req          = '0;
      sample_valid = 1'b0;
      sample       = '0;
      vis_valid    = 1'b0;
      vis          = '0;
      arst_n_i     = 1'b0;
      data_errs    = 0;
      cfg_errs     = 0;
      resp_errs    = 0;
      other_errs   = 0;
      repeat (10) @(posedge b_clk);
      #2 arst_n_i = 1'b1;

      fd = $fopen("verification/tart_cases.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("Could not open verification/tart_cases.txt");
      end
      // Stop early once a transfer has hung
      while (fd != 0 && other_errs == 0 && $fgets(line, fd) != 0) begin
         n = $sscanf(line, "%s %h %h %h", op, a, b, c);
         if (n == 4) begin  // Comment and blank lines fall out here
            case (op)
               "write": begin
                  apb_transfer(a[7:0], 1'b1, b[7:0], rd, err, lat);
                  check_resp(err, c[0], $sformatf("write to %h", a[7:0]));
                  check_data(8'(lat), 8'd2, "write pready cycle");
               end
               "read": begin
                  apb_transfer(a[7:0], 1'b0, '0, rd, err, lat);
                  check_data(rd, b[7:0], $sformatf("read of %h", a[7:0]));
                  check_resp(err, c[0], $sformatf("read of %h", a[7:0]));
                  check_data(8'(lat), 8'd2, "read pready cycle");
               end
               "sample": drive_stream(1'b0, a[7:0], b);
               "vis":    drive_stream(1'b1, a[7:0], b);
               "idle":   idle_check(a, tart_data_pkg::aq_cfg_t'(b[4:0]));
               default: begin
                  other_errs++;
                  $display("Unknown opcode in cases file: %s", op);
               end
            endcase
         end
      end
      if (fd != 0) $fclose(fd);

      $display("Errors: data %0d, settings %0d, response %0d, other %0d",
               data_errs, cfg_errs, resp_errs, other_errs);
      if (data_errs + cfg_errs + resp_errs + other_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verification/tart_cases.txt
# opcode arg value expect, numbers in hex
# write addr data err | read addr data err | sample data count 0
# vis data count 0 | idle cycles cfg 0
idle 1 00 0
read 0d 00 0
write 00 1d 0
idle 1 1d 0
read 00 1d 0
sample 05 1 0
sample 4a 1 0
sample 83 1 0
write 00 00 0
sample 3f 2 0
read 03 03 0
read 01 05 0
read 01 4a 0
read 01 83 0
vis 10 1 0
vis 22 1 0
vis f0 1 0
read 03 30 0
read 0e 22 0
read 04 03 0
read 02 10 0
read 02 22 0
read 02 f0 0
vis 01 9 0
read 0d 42 0
read 01 00 0
read 0d c2 0
read 0e 2a 0
write 00 10 0
idle 1 10 0
read 0d d2 0
write 0c 01 0
idle 6 00 0
read 0d 00 0
read 0c 00 0
read 03 00 0
read 0e 00 0
read 04 00 0
read 08 00 1
write 40 55 1
read 20 00 1

// File: build.f
rtl/tart_bus_pkg.sv
rtl/tart_data_pkg.sv
rtl/tart_stream_fifo.sv
rtl/tart_apb_decode.sv
rtl/tart_control.sv
rtl/tart_acquire.sv
rtl/tart_result_mux.sv
rtl/tart_top.sv
verification/tart_tb.sv
